//--- riscv_em.f
+incdir+design
design/riscv_em_pkg.sv
design/riscv_em_decode.sv
design/riscv_em_execute.sv
design/riscv_em_ppreg.sv
design/riscv_em_result.sv
design/riscv_em_top.sv
bench/riscv_em_props.sv
bench/riscv_em_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= riscv_em_tb
FILELIST  ?= riscv_em.f
PASS_MSG  := all tests passed

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out=$$(./$(BIN) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/riscv_em_tb.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_tb
    import riscv_em_pkg::*;
;

    typedef struct packed
    {
        logic [31:0]               instr;
        logic [`RISCV_EM_XLEN-1:0] pc;
        logic [`RISCV_EM_XLEN-1:0] rs1;
        logic [`RISCV_EM_XLEN-1:0] rs2;
        logic                      valid;
        logic                      stall;
        logic                      flush;
        logic                      exp_evt;   // row produces a report
        logic                      is_trap;
        logic [3:0]                cause;
        logic                      wb_en;
        logic [4:0]                rd;
        logic [`RISCV_EM_XLEN-1:0] data;
        logic                      chk_lat;
        logic [31:0]               due;       // cycle the report is due
    } row_t;

    logic                      i_riscv_em_clk;
    logic                      i_riscv_em_rst;
    logic                      i_valid;
    logic [31:0]               i_instr;
    logic [`RISCV_EM_XLEN-1:0] i_pc;
    logic [`RISCV_EM_XLEN-1:0] i_rs1_data;
    logic [`RISCV_EM_XLEN-1:0] i_rs2_data;
    logic                      i_stall;
    logic                      i_flush;
    logic                      o_retire;
    logic [`RISCV_EM_XLEN-1:0] o_retire_pc;
    logic                      o_wb_en;
    logic [4:0]                o_wb_rd;
    logic [`RISCV_EM_XLEN-1:0] o_wb_data;
    logic                      o_trap_valid;
    trap_cause_e               o_trap_cause;
    logic [`RISCV_EM_XLEN-1:0] o_trap_pc;

    row_t        rows[$];
    row_t        expq[$];
    row_t        ev;
    int unsigned cycles = 0;
    int unsigned limit  = 1000;
    int          errors = 0;
    logic [63:0] dval;

    riscv_em_top riscv_em_top_inst (.*);

    initial
    begin
        i_riscv_em_clk = 1'b0;
        forever #4 i_riscv_em_clk = ~i_riscv_em_clk;
    end

    always @(posedge i_riscv_em_clk)
    begin
        cycles <= cycles + 1;
    end

    task automatic fail_now();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd,
                                          logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(logic [11:0] imm, logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    // append one table row with pc taken from the row index
    task automatic add_row(logic [31:0] instr, logic [63:0] rs1, logic [63:0] rs2,
                           logic valid, logic stall, logic flush, logic exp_evt,
                           logic is_trap, logic [3:0] cause, logic [4:0] rd,
                           logic [63:0] data, logic chk_lat);
        row_t r;
        r         = '0;
        r.instr   = instr;
        r.pc      = 64'h1000 + 64'(4 * rows.size());
        r.rs1     = rs1;
        r.rs2     = rs2;
        r.valid   = valid;
        r.stall   = stall;
        r.flush   = flush;
        r.exp_evt = exp_evt;
        r.is_trap = is_trap;
        r.cause   = cause;
        r.wb_en   = exp_evt && !is_trap && (rd != 5'd0);
        r.rd      = rd;
        r.data    = data;
        r.chk_lat = chk_lat;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [63:0] x;
        logic [63:0] y;
        x = {$urandom, $urandom};
        y = {$urandom, $urandom};
        add_row(r_type(7'h00, 3'b000, 5'd5), x, y, 1, 0, 0, 1, 0, 0, 5'd5, x + y, 1);
        x = {$urandom, $urandom};
        y = {$urandom, $urandom};
        add_row(r_type(7'h20, 3'b000, 5'd6), x, y, 1, 0, 0, 1, 0, 0, 5'd6, x - y, 1);
        add_row(r_type(7'h00, 3'b111, 5'd7), x, y, 1, 0, 0, 1, 0, 0, 5'd7, x & y, 1);
        add_row(r_type(7'h00, 3'b110, 5'd8), x, y, 1, 0, 0, 1, 0, 0, 5'd8, x | y, 1);
        add_row(r_type(7'h00, 3'b100, 5'd9), x, y, 1, 0, 0, 1, 0, 0, 5'd9, x ^ y, 1);
        add_row(i_type(12'hFFB, 3'b000, 5'd10, 7'b0010011), x, y, 1, 0, 0, 1, 0, 0,
                5'd10, x - 64'd5, 1);
        add_row({20'hFEDCB, 5'd11, 7'b0110111}, x, y, 1, 0, 0, 1, 0, 0, 5'd11,
                {32'hFFFF_FFFF, 32'hFEDC_B000}, 1);
        // memory round trips where stores retire without write-back
        dval = {$urandom, $urandom};
        add_row(s_type(12'd8, 3'b011), 64'h20, dval, 1, 0, 0, 1, 0, 0, 5'd0, 64'd0, 0);
        add_row(i_type(12'd8, 3'b011, 5'd12, 7'b0000011), 64'h20, 0, 1, 0, 0, 1, 0, 0,
                5'd12, dval, 0);
        add_row(s_type(12'd4, 3'b010), 64'h40, 64'h8000_1234, 1, 0, 0, 1, 0, 0, 5'd0, 0, 0);
        add_row(i_type(12'd4, 3'b010, 5'd13, 7'b0000011), 64'h40, 0, 1, 0, 0, 1, 0, 0,
                5'd13, 64'hFFFF_FFFF_8000_1234, 0);
        add_row(s_type(12'd0, 3'b011), 64'h60, 64'h8877_6655_4433_2211, 1, 0, 0, 1, 0, 0,
                5'd0, 0, 0);
        add_row(i_type(12'd7, 3'b100, 5'd14, 7'b0000011), 64'h60, 0, 1, 0, 0, 1, 0, 0,
                5'd14, 64'h88, 0);
        // illegal, ecall, misaligned lw and misaligned sd traps
        add_row(32'hFFFF_FFFF, 0, 0, 1, 0, 0, 1, 1, 4'd2, 5'd0, 0, 0);
        add_row(32'h0000_0073, 0, 0, 1, 0, 0, 1, 1, 4'd11, 5'd0, 0, 0);
        add_row(i_type(12'd2, 3'b010, 5'd15, 7'b0000011), 64'h28, 0, 1, 0, 0, 1, 1, 4'd4,
                5'd0, 0, 0);
        add_row(s_type(12'd4, 3'b011), 64'h28, ~dval, 1, 0, 0, 1, 1, 4'd6, 5'd0, 0, 0);
        add_row(i_type(12'd0, 3'b011, 5'd16, 7'b0000011), 64'h28, 0, 1, 0, 0, 1, 0, 0,
                5'd16, dval, 0);
        // stall held over three cycles with two instructions in flight
        add_row(r_type(7'h00, 3'b000, 5'd17), x, 64'd1, 1, 0, 0, 1, 0, 0, 5'd17, x + 1, 0);
        add_row(r_type(7'h00, 3'b000, 5'd18), x, 64'd2, 1, 0, 0, 1, 0, 0, 5'd18, x + 2, 0);
        repeat (3) add_row(32'd0, 0, 0, 0, 1, 0, 0, 0, 0, 5'd0, 0, 0);
        add_row(r_type(7'h00, 3'b000, 5'd19), x, 64'd3, 1, 0, 0, 1, 0, 0, 5'd19, x + 3, 0);
        // flush drops the younger instruction and the one beside it
        add_row(r_type(7'h00, 3'b000, 5'd20), y, 64'd4, 1, 0, 0, 1, 0, 0, 5'd20, y + 4, 0);
        add_row(r_type(7'h00, 3'b000, 5'd21), y, 64'd5, 1, 0, 0, 0, 0, 0, 5'd21, 0, 0);
        add_row(r_type(7'h00, 3'b000, 5'd22), y, 64'd6, 1, 0, 1, 0, 0, 0, 5'd22, 0, 0);
        add_row(r_type(7'h00, 3'b000, 5'd23), y, 64'd7, 1, 0, 0, 1, 0, 0, 5'd23, y + 7, 0);
    endtask

    initial
    begin
        void'($urandom(32'h7814));
        i_riscv_em_rst = 1'b1;
        i_valid        = 1'b0;
        i_instr        = '0;
        i_pc           = '0;
        i_rs1_data     = '0;
        i_rs2_data     = '0;
        i_stall        = 1'b0;
        i_flush        = 1'b0;
        build_table();
        limit = rows.size() * 4 + 50;
        repeat (5) @(posedge i_riscv_em_clk);
        i_riscv_em_rst <= 1'b0;
        foreach (rows[i])
        begin
            @(posedge i_riscv_em_clk);
            i_valid    <= rows[i].valid;
            i_instr    <= rows[i].instr;
            i_pc       <= rows[i].pc;
            i_rs1_data <= rows[i].rs1;
            i_rs2_data <= rows[i].rs2;
            i_stall    <= rows[i].stall;
            i_flush    <= rows[i].flush;
            if (rows[i].exp_evt)
            begin
                ev     = rows[i];
                ev.due = cycles + 4;   // sampled next edge and reported two edges later
                expq.push_back(ev);
            end
        end
        @(posedge i_riscv_em_clk);
        i_valid <= 1'b0;
        i_stall <= 1'b0;
        i_flush <= 1'b0;
        while (expq.size() != 0)
        begin
            @(posedge i_riscv_em_clk);
        end
        repeat (4) @(posedge i_riscv_em_clk);   // catch stray reports
        if (errors == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            $display("tests failed");
            $fatal(1);
        end
    end

    always @(negedge i_riscv_em_clk)
    begin
        if (!i_riscv_em_rst && (o_retire || o_trap_valid))
        begin
            if (expq.size() == 0)
            begin
                $display("the DUT reported an instruction that was not expected, pc %h",
                         o_trap_valid ? o_trap_pc : o_retire_pc);
                fail_now();
            end
            ev = expq.pop_front();
            check_value("o_trap_valid", 64'(o_trap_valid), 64'(ev.is_trap));
            check_value("o_retire", 64'(o_retire), 64'(!ev.is_trap));
            if (ev.is_trap)
            begin
                check_value("o_trap_cause", 64'(o_trap_cause), 64'(ev.cause));
                check_value("o_trap_pc", o_trap_pc, ev.pc);
            end
            else
            begin
                check_value("o_retire_pc", o_retire_pc, ev.pc);
                check_value("o_wb_en", 64'(o_wb_en), 64'(ev.wb_en));
                check_value("o_wb_rd", 64'(o_wb_rd), 64'(ev.rd));
                check_value("o_wb_data", o_wb_data, ev.data);
            end
            if (ev.chk_lat)
            begin
                check_value("report cycle", 64'(cycles), 64'(ev.due));
            end
        end
    end

    always @(negedge i_riscv_em_clk)
    begin
        if (cycles > limit)
        begin
            $display("timeout after %0d cycles, %0d expected reports never came",
                     limit, expq.size());
            fail_now();
        end
    end

endmodule

//--- bench/riscv_em_props.sv
`timescale 1ns/1ps

module riscv_em_props
(
    input logic i_riscv_em_clk,
    input logic i_riscv_em_rst,
    input logic i_retire,
    input logic i_wb_en,
    input logic i_trap_valid
);

    // retire and trap are exclusive per cycle
    retire_trap_excl: assert property (
        @(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        !(i_retire && i_trap_valid)
    ) else $error("retire and trap reported in the same cycle");

    wb_needs_retire: assert property (
        @(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_wb_en |-> i_retire
    ) else $error("write-back enable without retire");

    quiet_in_reset: assert property (
        @(posedge i_riscv_em_clk)
        i_riscv_em_rst |-> (!i_retire && !i_trap_valid && !i_wb_en)
    ) else $error("output event while in reset");

endmodule

bind riscv_em_top riscv_em_props riscv_em_props_inst (
    .i_riscv_em_clk (i_riscv_em_clk),
    .i_riscv_em_rst (i_riscv_em_rst),
    .i_retire       (o_retire),
    .i_wb_en        (o_wb_en),
    .i_trap_valid   (o_trap_valid)
);

//--- design/riscv_em_top.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_top
    import riscv_em_pkg::*;
(
    input  logic                      i_riscv_em_clk,
    input  logic                      i_riscv_em_rst,
    input  logic                      i_valid,
    input  logic [31:0]               i_instr,
    input  logic [`RISCV_EM_XLEN-1:0] i_pc,
    input  logic [`RISCV_EM_XLEN-1:0] i_rs1_data,
    input  logic [`RISCV_EM_XLEN-1:0] i_rs2_data,
    input  logic                      i_stall,
    input  logic                      i_flush,
    output logic                      o_retire,
    output logic [`RISCV_EM_XLEN-1:0] o_retire_pc,
    output logic                      o_wb_en,
    output logic [4:0]                o_wb_rd,
    output logic [`RISCV_EM_XLEN-1:0] o_wb_data,
    output logic                      o_trap_valid,
    output trap_cause_e               o_trap_cause,
    output logic [`RISCV_EM_XLEN-1:0] o_trap_pc
);

    de_payload_t de_d;
    de_payload_t de_q;
    em_payload_t em_d;
    em_payload_t em_q;

    riscv_em_decode riscv_em_decode_inst (
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_de       (de_d)
    );

    riscv_em_ppreg #(.payload_t(de_payload_t)) riscv_em_ppreg_de_inst (
        .i_riscv_em_clk (i_riscv_em_clk),
        .i_riscv_em_rst (i_riscv_em_rst),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_d            (de_d),
        .o_q            (de_q)
    );

    riscv_em_execute riscv_em_execute_inst (
        .i_de (de_q),
        .o_em (em_d)
    );

    riscv_em_ppreg #(.payload_t(em_payload_t)) riscv_em_ppreg_em_inst (
        .i_riscv_em_clk (i_riscv_em_clk),
        .i_riscv_em_rst (i_riscv_em_rst),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_d            (em_d),
        .o_q            (em_q)
    );

    riscv_em_result riscv_em_result_inst (
        .i_riscv_em_clk (i_riscv_em_clk),
        .i_riscv_em_rst (i_riscv_em_rst),
        .i_stall        (i_stall),
        .i_em           (em_q),
        .o_retire       (o_retire),
        .o_wb_en        (o_wb_en),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data),
        .o_retire_pc    (o_retire_pc),
        .o_trap_pc      (o_trap_pc),
        .o_trap_valid   (o_trap_valid),
        .o_trap_cause   (o_trap_cause)
    );

endmodule

//--- design/riscv_em_result.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_result
    import riscv_em_pkg::*;
(
    input  logic                      i_riscv_em_clk,
    input  logic                      i_riscv_em_rst,
    input  logic                      i_stall,
    input  em_payload_t               i_em,
    output logic                      o_retire,
    output logic                      o_wb_en,
    output logic [4:0]                o_wb_rd,
    output logic [`RISCV_EM_XLEN-1:0] o_wb_data,
    output logic [`RISCV_EM_XLEN-1:0] o_retire_pc,
    output logic [`RISCV_EM_XLEN-1:0] o_trap_pc,
    output logic                      o_trap_valid,
    output trap_cause_e               o_trap_cause
);

    localparam int IDX_W  = $clog2(`RISCV_EM_DMEM_DEPTH);
    localparam int NBYTES = `RISCV_EM_XLEN / 8;

    logic [`RISCV_EM_XLEN-1:0] dmem [`RISCV_EM_DMEM_DEPTH];
    logic [IDX_W-1:0]          idx;
    logic [2:0]                offset;
    logic [`RISCV_EM_XLEN-1:0] rdata;
    logic [31:0]               ld_word;
    logic [7:0]                ld_byte;
    logic [`RISCV_EM_XLEN-1:0] ld_data;
    logic [NBYTES-1:0]         byte_mask;
    logic [`RISCV_EM_XLEN-1:0] st_lanes;
    logic [`RISCV_EM_XLEN-1:0] merged;
    logic [`RISCV_EM_XLEN-1:0] result;
    logic                      fire;
    logic                      store_en;

    assign idx     = i_em.alu_result[3 +: IDX_W];   // upper address bits wrap
    assign offset  = i_em.alu_result[2:0];
    assign rdata   = dmem[idx];
    assign ld_word = rdata[{offset[2], 5'b00000} +: 32];
    assign ld_byte = rdata[{offset, 3'b000} +: 8];

    always_comb
    begin
        case (i_em.mem_ext)
            MEM_WORD_S:
            begin
                ld_data   = {{(`RISCV_EM_XLEN-32){ld_word[31]}}, ld_word};
                byte_mask = NBYTES'(4'hF) << {offset[2], 2'b00};
                st_lanes  = {(NBYTES/4){i_em.store_data[31:0]}};
            end
            MEM_BYTE_U:
            begin
                ld_data   = {{(`RISCV_EM_XLEN-8){1'b0}}, ld_byte};
                byte_mask = NBYTES'(1) << offset;
                st_lanes  = {NBYTES{i_em.store_data[7:0]}};
            end
            default:
            begin
                ld_data   = rdata;
                byte_mask = '1;
                st_lanes  = i_em.store_data;
            end
        endcase
        for (int b = 0; b < NBYTES; b++)
        begin
            merged[8*b +: 8] = byte_mask[b] ? st_lanes[8*b +: 8] : rdata[8*b +: 8];
        end
    end

    assign result = (i_em.result_src == RES_LOAD) ? ld_data :
                    (i_em.result_src == RES_ALU)  ? i_em.alu_result : '0;

    assign fire     = i_em.valid & ~i_stall;
    assign store_en = fire & i_em.mem_write;

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
        begin
            for (int i = 0; i < `RISCV_EM_DMEM_DEPTH; i++)
            begin
                dmem[i] <= '0;
            end
        end
        else if (store_en)
        begin
            dmem[idx] <= merged;
        end
    end

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
        begin
            o_retire     <= 1'b0;
            o_wb_en      <= 1'b0;
            o_wb_rd      <= '0;
            o_wb_data    <= '0;
            o_retire_pc  <= '0;
            o_trap_valid <= 1'b0;
            o_trap_cause <= TRAP_NONE;
            o_trap_pc    <= '0;
        end
        else
        begin
            o_retire     <= fire & ~i_em.trap;            // single-cycle pulses
            o_wb_en      <= fire & ~i_em.trap & i_em.reg_write;
            o_trap_valid <= fire & i_em.trap;
            if (fire && !i_em.trap)
            begin
                o_wb_rd     <= i_em.rd;
                o_wb_data   <= result;
                o_retire_pc <= i_em.pc;
            end
            if (fire && i_em.trap)
            begin
                o_trap_cause <= i_em.trap_cause;
                o_trap_pc    <= i_em.pc;
            end
        end
    end

endmodule

//--- design/riscv_em_ppreg.sv
`timescale 1ns/1ps

module riscv_em_ppreg #(
    parameter type payload_t = logic
) (
    input  logic     i_riscv_em_clk,
    input  logic     i_riscv_em_rst,
    input  logic     i_stall,
    input  logic     i_flush,
    input  payload_t i_d,
    output payload_t o_q
);

    // flush wins over stall, a cleared payload is a bubble
    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
        begin
            o_q <= '0;
        end
        else if (i_flush)
        begin
            o_q <= '0;
        end
        else if (!i_stall)
        begin
            o_q <= i_d;
        end
    end

endmodule

//--- design/riscv_em_execute.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_execute
    import riscv_em_pkg::*;
(
    input  de_payload_t i_de,
    output em_payload_t o_em
);

    logic [`RISCV_EM_XLEN-1:0] op_b;
    logic [`RISCV_EM_XLEN-1:0] alu_res;
    logic                      misaligned;
    logic                      load_mis;
    logic                      store_mis;

    assign op_b = i_de.use_imm ? i_de.imm : i_de.rs2_data;

    // loads and stores come through as add, giving the address
    always_comb
    begin
        case (i_de.alu_op)
            ALU_ADD:      alu_res = i_de.rs1_data + op_b;
            ALU_SUB:      alu_res = i_de.rs1_data - op_b;
            ALU_AND:      alu_res = i_de.rs1_data & op_b;
            ALU_OR:       alu_res = i_de.rs1_data | op_b;
            ALU_XOR:      alu_res = i_de.rs1_data ^ op_b;
            ALU_PASS_IMM: alu_res = i_de.imm;
            default:      alu_res = i_de.rs1_data + op_b;
        endcase
    end

    always_comb
    begin
        case (i_de.mem_ext)
            MEM_DOUBLE: misaligned = (alu_res[2:0] != 3'b000);
            MEM_WORD_S: misaligned = (alu_res[1:0] != 2'b00);
            default:    misaligned = 1'b0;                      // byte access
        endcase
    end

    assign load_mis  = i_de.mem_read & misaligned;
    assign store_mis = i_de.mem_write & misaligned;

    always_comb
    begin
        o_em            = '0;
        o_em.valid      = i_de.valid;
        o_em.pc         = i_de.pc;
        o_em.alu_result = alu_res;
        o_em.store_data = i_de.rs2_data;
        o_em.rd         = i_de.rd;
        o_em.reg_write  = i_de.reg_write;
        o_em.result_src = i_de.result_src;
        o_em.mem_read   = i_de.mem_read;
        o_em.mem_write  = i_de.mem_write;
        o_em.mem_ext    = i_de.mem_ext;
        o_em.trap_cause = TRAP_NONE;
        if (i_de.valid)
        begin
            if (i_de.illegal)
            begin
                o_em.trap       = 1'b1;
                o_em.trap_cause = TRAP_ILLEGAL;
            end
            else if (i_de.ecall)
            begin
                o_em.trap       = 1'b1;
                o_em.trap_cause = TRAP_ECALL_M;
            end
            else if (load_mis)
            begin
                o_em.trap       = 1'b1;
                o_em.trap_cause = TRAP_LOAD_MISALIGN;
            end
            else if (store_mis)
            begin
                o_em.trap       = 1'b1;
                o_em.trap_cause = TRAP_STORE_MISALIGN;
            end
        end
        if (o_em.trap)
        begin
            o_em.reg_write = 1'b0;   // trap has no side effects
            o_em.mem_write = 1'b0;
            o_em.mem_read  = 1'b0;
        end
    end

endmodule

//--- design/riscv_em_decode.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_decode
    import riscv_em_pkg::*;
(
    input  logic                      i_valid,
    input  logic [31:0]               i_instr,
    input  logic [`RISCV_EM_XLEN-1:0] i_pc,
    input  logic [`RISCV_EM_XLEN-1:0] i_rs1_data,
    input  logic [`RISCV_EM_XLEN-1:0] i_rs2_data,
    output de_payload_t               o_de
);

    localparam logic [6:0]  OPC_OP      = 7'b0110011;
    localparam logic [6:0]  OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0]  OPC_LUI     = 7'b0110111;
    localparam logic [6:0]  OPC_LOAD    = 7'b0000011;
    localparam logic [6:0]  OPC_STORE   = 7'b0100011;
    localparam logic [6:0]  OPC_SYSTEM  = 7'b1110011;
    localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [`RISCV_EM_XLEN-1:0] imm_i;
    logic [`RISCV_EM_XLEN-1:0] imm_s;
    logic [`RISCV_EM_XLEN-1:0] imm_u;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{(`RISCV_EM_XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{(`RISCV_EM_XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_u = {{(`RISCV_EM_XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};

    always_comb
    begin
        o_de            = '0;
        o_de.valid      = i_valid;
        o_de.pc         = i_pc;
        o_de.rs1_data   = i_rs1_data;
        o_de.rs2_data   = i_rs2_data;
        o_de.alu_op     = ALU_ADD;
        o_de.result_src = RES_NONE;
        o_de.mem_ext    = MEM_DOUBLE;
        case (opcode)
            OPC_OP:
            begin
                o_de.reg_write  = 1'b1;
                o_de.result_src = RES_ALU;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: o_de.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: o_de.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: o_de.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: o_de.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: o_de.alu_op = ALU_XOR;
                    default:              o_de.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM:
            begin
                o_de.imm        = imm_i;
                o_de.use_imm    = 1'b1;
                o_de.reg_write  = 1'b1;
                o_de.result_src = RES_ALU;
                o_de.illegal    = (funct3 != 3'b000);    // only addi
            end
            OPC_LUI:
            begin
                o_de.imm        = imm_u;
                o_de.use_imm    = 1'b1;
                o_de.alu_op     = ALU_PASS_IMM;
                o_de.reg_write  = 1'b1;
                o_de.result_src = RES_ALU;
            end
            OPC_LOAD:
            begin
                o_de.imm        = imm_i;
                o_de.use_imm    = 1'b1;
                o_de.mem_read   = 1'b1;
                o_de.reg_write  = 1'b1;
                o_de.result_src = RES_LOAD;
                case (funct3)
                    3'b011:  o_de.mem_ext = MEM_DOUBLE;
                    3'b010:  o_de.mem_ext = MEM_WORD_S;
                    3'b100:  o_de.mem_ext = MEM_BYTE_U;
                    default: o_de.illegal = 1'b1;
                endcase
            end
            OPC_STORE:
            begin
                o_de.imm       = imm_s;
                o_de.use_imm   = 1'b1;
                o_de.mem_write = 1'b1;
                case (funct3)
                    3'b011:  o_de.mem_ext = MEM_DOUBLE;
                    3'b010:  o_de.mem_ext = MEM_WORD_S;
                    default: o_de.illegal = 1'b1;
                endcase
            end
            OPC_SYSTEM:
            begin
                o_de.ecall   = (i_instr == INSTR_ECALL);
                o_de.illegal = (i_instr != INSTR_ECALL);
            end
            default:
            begin
                o_de.illegal = 1'b1;
            end
        endcase
        if (o_de.illegal)
        begin
            o_de.reg_write  = 1'b0;
            o_de.mem_read   = 1'b0;
            o_de.mem_write  = 1'b0;
            o_de.result_src = RES_NONE;
        end
        o_de.rd = o_de.reg_write ? i_instr[11:7] : 5'd0;   // no write, no rd
    end

endmodule

//--- design/riscv_em_pkg.sv
`include "riscv_em_config.svh"

package riscv_em_pkg;

    typedef enum logic [2:0]
    {
        ALU_ADD      = 3'd0,
        ALU_SUB      = 3'd1,
        ALU_AND      = 3'd2,
        ALU_OR       = 3'd3,
        ALU_XOR      = 3'd4,
        ALU_PASS_IMM = 3'd5
    } alu_op_e;

    typedef enum logic [1:0]
    {
        RES_ALU  = 2'd0,
        RES_LOAD = 2'd1,
        RES_NONE = 2'd2
    } result_src_e;

    typedef enum logic [1:0]
    {
        MEM_DOUBLE = 2'd0,
        MEM_WORD_S = 2'd1,
        MEM_BYTE_U = 2'd2
    } mem_ext_e;

    // standard exception codes, none only for idle outputs
    typedef enum logic [3:0]
    {
        TRAP_NONE            = 4'd0,
        TRAP_ILLEGAL         = 4'd2,
        TRAP_LOAD_MISALIGN   = 4'd4,
        TRAP_STORE_MISALIGN  = 4'd6,
        TRAP_ECALL_M         = 4'd11
    } trap_cause_e;

    typedef struct packed
    {
        logic                      valid;
        logic [`RISCV_EM_XLEN-1:0] pc;
        logic [`RISCV_EM_XLEN-1:0] rs1_data;
        logic [`RISCV_EM_XLEN-1:0] rs2_data;
        logic [`RISCV_EM_XLEN-1:0] imm;
        logic [4:0]                rd;
        alu_op_e                   alu_op;
        logic                      use_imm;      // operand b from immediate
        logic                      reg_write;
        result_src_e               result_src;
        logic                      mem_read;
        logic                      mem_write;
        mem_ext_e                  mem_ext;
        logic                      illegal;
        logic                      ecall;
    } de_payload_t;

    typedef struct packed
    {
        logic                      valid;
        logic [`RISCV_EM_XLEN-1:0] pc;
        logic [`RISCV_EM_XLEN-1:0] alu_result;   // also the memory address
        logic [`RISCV_EM_XLEN-1:0] store_data;
        logic [4:0]                rd;
        logic                      reg_write;
        result_src_e               result_src;
        logic                      mem_read;
        logic                      mem_write;
        mem_ext_e                  mem_ext;
        logic                      trap;
        trap_cause_e               trap_cause;
    } em_payload_t;

endpackage

//--- design/riscv_em_config.svh
`ifndef RISCV_EM_CONFIG_SVH
`define RISCV_EM_CONFIG_SVH

// data and address width
`define RISCV_EM_XLEN 64

// data memory size in doublewords, indexed above the byte offset
`define RISCV_EM_DMEM_DEPTH 16

`endif
